//--- Bender.yml
package:
  name: proc

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - fetch/fetch.sv
      - decode/decode.sv
      - rtl/execute.sv
      - rtl/memory.sv
      - rtl/proc.sv
  - target: test
    files:
      - bench/proc_chk.sv
      - bench/proc_tb.sv

//--- bench/proc_chk.sv
/* Concurrent checks on the core's retire and status ports, bound into proc */
`timescale 1ns/1ps
`default_nettype none

module proc_chk (
    input logic clk,
    input logic reset,
    input logic wbValid,
    input logic halted
);

    int failures;   // Failed assertions so far

    // Pipeline valid bits are clear after the first reset edge
    wbQuietInReset: assert property (@(posedge clk) (reset ##1 reset) |-> !wbValid)
        else begin
            failures++;
            $error("wbValid high while reset is held");
        end

    haltedSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else begin
            failures++;
            $error("halted fell without a reset");
        end

    // Nothing retires once HALT has reached writeback
    noWbAfterHalt: assert property (@(posedge clk) disable iff (reset) halted |-> !wbValid)
        else begin
            failures++;
            $error("register write retired after halt");
        end

endmodule

bind proc proc_chk u_chk (
    .clk(clk), .reset(reset), .wbValid(wbValid), .halted(halted)
);
`default_nettype wire

//--- bench/proc_golden.hex
// Word 0 program length, then the program words, then the writeback count
// Each record after the count is a register index and its expected value
0023
C105 C2FD C37F 419E     // LBI R1,5  LBI R2,-3  LBI R3,127  ADDI R4,R1,-2
D954 DA79 DB43 DCBE     // ADD R5  SUB R6  AND R0  XOR R7
C140 0800 0800          // LBI R1,0x40 base, two NOPs
8103 81C2 8942 8963     // ST R0,[R1+3]  ST R6,[R1+2]  LD R2,[R1+2]  LD R3,[R1+3]
F800                    // Undefined opcode
6402 C400 0800 0800     // BEQZ R4 not taken, LBI R4,0
6402 C511 C522          // BEQZ R4 taken to 23, delay slot, skipped
6F02 47C1 C633          // BNEZ R7 taken to 26, ADDI R6,R7,1, skipped
2002 C001 C055          // J to 29, delay slot, skipped
3003 0800 C166 C177     // JAL to 33, delay NOP, two skipped
0000 C201               // HALT, never issued
0010
1 0005
2 FFFD
3 007F
4 0003
5 0002
6 FF7E
0 007D
7 0001
1 0040
2 FF7E
3 007D
4 0000
5 0011
6 0002
0 0001
7 001E

//--- bench/proc_tb.sv
/* Testbench for the pipelined core. Loads the program image from the golden
   file, starts the run and checks each retired register write in order */
`timescale 1ns/1ps
`default_nettype none

module proc_tb import isaPkg::*; ();

    localparam int GOLDEN_DEPTH = 128;

    logic      clk;
    logic      reset;
    logic      imemWrEn;
    imemAddr_t imemAddr;
    instr_t    imemData;
    logic      start;
    logic      wbValid;
    regAddr_t  wbAddr;
    word_t     wbData;
    logic      halted;
    logic      err;

    word_t golden [GOLDEN_DEPTH];   // Length, program, count, records
    int    progLen;
    int    expCount;
    int    recBase;                 // Index of first record
    int    wbSeen;
    int    errors;
    int    checks;

    proc u_proc (
        .clk(clk), .reset(reset),
        .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
        .start(start),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .halted(halted), .err(err)
    );

    always #2 clk = ~clk;           // 4 ns period

    // Compare one retired write with the next golden record
    task automatic checkWriteback();
        regAddr_t expAddr;
        word_t    expData;
        checks++;
        assert (wbSeen < expCount) else begin
            errors++;
            $display("Unexpected writeback to R%0d after all %0d expected ones", wbAddr, expCount);
        end
        if (wbSeen < expCount) begin
            expAddr = regAddr_t'(golden[recBase + 2 * wbSeen]);
            expData = golden[recBase + 2 * wbSeen + 1];
            assert (wbAddr == expAddr && wbData == expData) else begin
                errors++;
                $display("ERROR %0t ns: writeback %0d is R%0d = %h, expected R%0d = %h",
                         $time, wbSeen, wbAddr, wbData, expAddr, expData);
            end
        end
        wbSeen++;
    endtask

    // One imem write per cycle
    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            @(posedge clk);
            imemWrEn <= 1'b1;
            imemAddr <= imemAddr_t'(i);
            imemData <= golden[1 + i];
        end
        @(posedge clk);
        imemWrEn <= 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic waitForHalt(input int limit, output logic timedOut);
        int cycles;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        timedOut = !halted;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset && wbValid) begin
            checkWriteback();
        end
    end

    initial begin
        int   limit;
        logic timedOut;
        clk      = 1'b0;
        reset    = 1'b1;
        imemWrEn = 1'b0;
        imemAddr = '0;
        imemData = '0;
        start    = 1'b0;
        errors   = 0;
        checks   = 0;
        wbSeen   = 0;
        $readmemh("bench/proc_golden.hex", golden);
        progLen  = int'(golden[0]);
        expCount = int'(golden[progLen + 1]);
        recBase  = progLen + 2;
        limit    = progLen * 2 + 50;       // Bound on the run in cycles

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checks++;
        assert (!wbValid && !halted && !err) else begin
            errors++;
            $display("ERROR %0t ns: status outputs not clear after reset", $time);
        end

        loadProgram();
        pulseStart();
        waitForHalt(limit, timedOut);
        if (timedOut) begin
            errors++;
            $display("Timeout: halted did not rise within %0d cycles", limit);
        end else begin
            repeat (6) @(negedge clk);     // Room for a stray writeback
            checks++;
            assert (wbSeen == expCount) else begin
                errors++;
                $display("Saw %0d writebacks but the golden file expects %0d",
                         wbSeen, expCount);
            end
            checks++;
            assert (err) else begin        // Program holds one undefined opcode
                errors++;
                $display("ERROR %0t ns: err flag not set after undefined opcode", $time);
            end
        end

        errors += u_proc.u_chk.failures;   // Bound port assertions
        $display("Checks: %0d  writebacks: %0d  errors: %0d", checks, wbSeen, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
`default_nettype wire

//--- common/isaPkg.sv
/* Machine-level types: data words, instruction words and instruction fields.
   Imported by every stage of the core */
`default_nettype none

package isaPkg;

    typedef logic [15:0] word_t;      // Data value or address
    typedef logic [15:0] instr_t;     // Raw instruction
    typedef logic [2:0]  regAddr_t;   // R0..R7
    typedef logic [4:0]  opcode_t;    // Bits 15:11
    typedef logic [1:0]  funct_t;     // Bits 1:0 of R-type
    typedef logic [7:0]  imemAddr_t;  // Instruction memory index

endpackage

`default_nettype wire

//--- common/pipePkg.sv
/* Pipeline control types: destination select, ALU operation and the
   fetch state machine */
`default_nettype none

package pipePkg;

    typedef logic [1:0] destSel_t;    // Rs, Rd-R, R7, Rd-I
    typedef logic [2:0] aluOp_t;      // See ALU_* codes

    // Fetch sequencing
    typedef enum logic [1:0] {
        LOAD,
        RUN,
        HALTED
    } fetchState_t;

endpackage

`default_nettype wire

//--- common/proc_consts.svh
/* Shared encodings for the 16-bit pipelined core: opcodes, funct codes,
   ALU operation codes, destination selects and memory depths */
`default_nettype none
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

`define PROC_IMEM_DEPTH 256
`define PROC_DMEM_DEPTH 256

`define OP_HALT  5'b00000
`define OP_NOP   5'b00001
`define OP_J     5'b00100
`define OP_JAL   5'b00110
`define OP_ADDI  5'b01000
`define OP_BEQZ  5'b01100
`define OP_BNEZ  5'b01101
`define OP_ST    5'b10000
`define OP_LD    5'b10001
`define OP_LBI   5'b11000
`define OP_RTYPE 5'b11011   // ADD/SUB/XOR/AND by funct

`define FN_ADD 2'b00
`define FN_SUB 2'b01
`define FN_XOR 2'b10
`define FN_AND 2'b11

`define ALU_ADD  3'd0
`define ALU_SUB  3'd1
`define ALU_AND  3'd2
`define ALU_XOR  3'd3
`define ALU_PASS 3'd4   // Pass B, used by LBI
`define ALU_LINK 3'd5   // Pass A, carries PC+1 for JAL

`define DEST_RS  2'd0
`define DEST_RDR 2'd1
`define DEST_R7  2'd2
`define DEST_RDI 2'd3

`endif
`default_nettype wire

//--- decode/decode.sv
/* Decode stage. Control decode, write-through register file, immediates,
   branch resolution with one delay slot, and the ID/EX register */
`timescale 1ns/1ps
`include "proc_consts.svh"
`default_nettype none

module decode import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  instr_t   ifInstr,
    input  word_t    ifPcNext,
    input  logic     ifValid,
    input  logic     wbEn,
    input  regAddr_t wbAddr,
    input  word_t    wbData,
    output logic     branchTaken,
    output word_t    branchTarget,
    output logic     haltSeen,
    output word_t    exRsVal,
    output word_t    exRtVal,
    output word_t    exImm,
    output aluOp_t   exAluOp,
    output logic     exAluSrcImm,
    output logic     exMemEn,
    output logic     exMemWr,
    output logic     exMemToReg,
    output logic     exRegWrite,
    output logic     exHalt,
    output regAddr_t exDest,
    output logic     exValid,
    output logic     illegalOp
);

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    regAddr_t rdAddr;
    word_t    regs [8];
    word_t    rsVal;
    word_t    rtVal;
    word_t    imm;
    aluOp_t   aluOp;
    destSel_t destSel;
    regAddr_t destAddr;
    logic     aluSrcImm;
    logic     memEn;
    logic     memWr;
    logic     memToReg;
    logic     regWrite;
    logic     isHalt;
    logic     illegal;
    logic     takeBranch;

    assign opcode = ifInstr[15:11];
    assign rsAddr = ifInstr[10:8];
    assign rtAddr = ifInstr[7:5];
    assign rdAddr = ifInstr[4:2];
    assign funct  = ifInstr[1:0];

    // Same-cycle writeback is visible to the read
    assign rsVal = (wbEn && wbAddr == rsAddr) ? wbData : regs[rsAddr];
    assign rtVal = (wbEn && wbAddr == rtAddr) ? wbData : regs[rtAddr];

    always_ff @(posedge clk) begin
        if (wbEn) begin
            regs[wbAddr] <= wbData;
        end
    end

    always_comb begin
        imm        = {{11{ifInstr[4]}}, ifInstr[4:0]};  // 5-bit form unless overridden
        aluOp      = `ALU_ADD;
        aluSrcImm  = 1'b0;
        memEn      = 1'b0;
        memWr      = 1'b0;
        memToReg   = 1'b0;
        regWrite   = 1'b0;
        destSel    = `DEST_RS;
        isHalt     = 1'b0;
        illegal    = 1'b0;
        takeBranch = 1'b0;
        case (opcode)
            `OP_NOP: ;                                  // Idle slot
            `OP_HALT: isHalt = 1'b1;
            `OP_ADDI: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                destSel   = `DEST_RDI;
            end
            `OP_LBI: begin
                imm       = {{8{ifInstr[7]}}, ifInstr[7:0]};
                aluOp     = `ALU_PASS;
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            `OP_LD: begin
                aluSrcImm = 1'b1;                       // Rs + offset
                memEn     = 1'b1;
                memToReg  = 1'b1;
                regWrite  = 1'b1;
                destSel   = `DEST_RDI;
            end
            `OP_ST: begin
                aluSrcImm = 1'b1;
                memEn     = 1'b1;
                memWr     = 1'b1;                       // Data comes from Rt field
            end
            `OP_BEQZ: begin
                imm        = {{8{ifInstr[7]}}, ifInstr[7:0]};
                takeBranch = (rsVal == 16'd0);
            end
            `OP_BNEZ: begin
                imm        = {{8{ifInstr[7]}}, ifInstr[7:0]};
                takeBranch = (rsVal != 16'd0);
            end
            `OP_J: begin
                imm        = {{5{ifInstr[10]}}, ifInstr[10:0]};
                takeBranch = 1'b1;
            end
            `OP_JAL: begin
                imm        = {{5{ifInstr[10]}}, ifInstr[10:0]};
                takeBranch = 1'b1;
                aluOp      = `ALU_LINK;
                regWrite   = 1'b1;
                destSel    = `DEST_R7;
            end
            `OP_RTYPE: begin
                regWrite = 1'b1;
                destSel  = `DEST_RDR;
                case (funct)
                    `FN_ADD: aluOp = `ALU_ADD;
                    `FN_SUB: aluOp = `ALU_SUB;
                    `FN_XOR: aluOp = `ALU_XOR;
                    default: aluOp = `ALU_AND;
                endcase
            end
            default: illegal = 1'b1;                    // Behaves as NOP
        endcase
    end

    always_comb begin
        case (destSel)
            `DEST_RS:  destAddr = rsAddr;
            `DEST_RDR: destAddr = rdAddr;
            `DEST_R7:  destAddr = 3'd7;
            default:   destAddr = rtAddr;               // Rd-I
        endcase
    end

    assign branchTaken  = ifValid & takeBranch;
    assign branchTarget = ifPcNext + imm;               // Relative to delay slot
    assign haltSeen     = ifValid & isHalt;
    assign illegalOp    = ifValid & illegal;

    // ID/EX strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemEn    <= 1'b0;
            exMemWr    <= 1'b0;
            exHalt     <= 1'b0;
        end else begin
            exValid    <= ifValid;
            exRegWrite <= ifValid & regWrite;
            exMemEn    <= ifValid & memEn;
            exMemWr    <= ifValid & memWr;
            exHalt     <= ifValid & isHalt;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        exRsVal     <= (aluOp == `ALU_LINK) ? ifPcNext : rsVal;  // JAL link value
        exRtVal     <= rtVal;
        exImm       <= imm;
        exAluOp     <= aluOp;
        exAluSrcImm <= aluSrcImm;
        exMemToReg  <= memToReg;
        exDest      <= destAddr;
    end

endmodule
`default_nettype wire

//--- fetch/fetch.sv
/* Fetch stage. Holds instruction memory, the PC and the load/run/halt FSM,
   and registers each fetched instruction into the IF/ID boundary */
`timescale 1ns/1ps
`include "proc_consts.svh"
`default_nettype none

module fetch import isaPkg::*, pipePkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        imemWrEn,
    input  imemAddr_t   imemAddr,
    input  instr_t      imemData,
    input  logic        start,
    input  logic        branchTaken,
    input  word_t       branchTarget,
    input  logic        haltSeen,
    output instr_t      ifInstr,
    output word_t       ifPcNext,
    output logic        ifValid
);

    fetchState_t state;
    word_t       pc;
    instr_t      imem [`PROC_IMEM_DEPTH];
    instr_t      curInstr;
    logic        issue;

    assign curInstr = imem[imemAddr_t'(pc)];    // Low PC bits index
    assign issue    = (state == RUN) && !haltSeen;

    // Program load, only while idle
    always_ff @(posedge clk) begin
        if (imemWrEn && state == LOAD) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= LOAD;
            pc      <= '0;
            ifValid <= 1'b0;
        end else begin
            ifValid <= issue;
            case (state)
                LOAD: begin
                    if (start) begin
                        state <= RUN;
                        pc    <= '0;
                    end
                end
                RUN: begin
                    if (haltSeen) begin
                        state <= HALTED;    // HALT in decode, stop here
                    end else begin
                        pc <= branchTaken ? branchTarget : pc + 16'd1;
                    end
                end
                HALTED: state <= HALTED;    // Left only by reset
                default: state <= LOAD;
            endcase
        end
    end

    // IF/ID payload, bubbles carry a NOP word
    always_ff @(posedge clk) begin
        ifInstr  <= issue ? curInstr : {`OP_NOP, 11'd0};
        ifPcNext <= pc + 16'd1;
    end

endmodule
`default_nettype wire

//--- rtl/execute.sv
/* Execute stage. ALU with register or immediate B operand, followed by
   the EX/MEM register */
`timescale 1ns/1ps
`include "proc_consts.svh"
`default_nettype none

module execute import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    exRsVal,
    input  word_t    exRtVal,
    input  word_t    exImm,
    input  aluOp_t   exAluOp,
    input  logic     exAluSrcImm,
    input  logic     exMemEn,
    input  logic     exMemWr,
    input  logic     exMemToReg,
    input  logic     exRegWrite,
    input  logic     exHalt,
    input  regAddr_t exDest,
    input  logic     exValid,
    output word_t    memAluOut,
    output word_t    memStoreData,
    output logic     memEn,
    output logic     memWr,
    output logic     memToReg,
    output logic     memRegWrite,
    output logic     memHalt,
    output regAddr_t memDest,
    output logic     memValid
);

    word_t opB;
    word_t aluOut;

    assign opB = exAluSrcImm ? exImm : exRtVal;

    always_comb begin
        case (exAluOp)
            `ALU_ADD:  aluOut = exRsVal + opB;
            `ALU_SUB:  aluOut = exRsVal - opB;      // Rs minus Rt
            `ALU_AND:  aluOut = exRsVal & opB;
            `ALU_XOR:  aluOut = exRsVal ^ opB;
            `ALU_PASS: aluOut = opB;                // LBI
            `ALU_LINK: aluOut = exRsVal;            // PC+1 from decode
            default:   aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            memValid    <= 1'b0;
            memEn       <= 1'b0;
            memWr       <= 1'b0;
            memRegWrite <= 1'b0;
            memHalt     <= 1'b0;
        end else begin
            memValid    <= exValid;
            memEn       <= exMemEn;
            memWr       <= exMemWr;
            memRegWrite <= exRegWrite;
            memHalt     <= exHalt;
        end
    end

    always_ff @(posedge clk) begin
        memAluOut    <= aluOut;
        memStoreData <= exRtVal;
        memToReg     <= exMemToReg;
        memDest      <= exDest;
    end

endmodule
`default_nettype wire

//--- rtl/memory.sv
/* Memory stage. Data memory with combinational read and clocked write,
   then the MEM/WB register */
`timescale 1ns/1ps
`include "proc_consts.svh"
`default_nettype none

module memory import isaPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    memAluOut,
    input  word_t    memStoreData,
    input  logic     memEn,
    input  logic     memWr,
    input  logic     memToReg,
    input  logic     memRegWrite,
    input  logic     memHalt,
    input  regAddr_t memDest,
    input  logic     memValid,
    output word_t    wbAluOut,
    output word_t    wbMemOut,
    output logic     wbMemToReg,
    output logic     wbRegWrite,
    output logic     wbHalt,
    output regAddr_t wbDest,
    output logic     wbValid
);

    word_t dmem [`PROC_DMEM_DEPTH];
    word_t readData;

    assign readData = dmem[memAluOut[7:0]];         // Low address byte

    always_ff @(posedge clk) begin
        if (memValid && memEn && memWr) begin
            dmem[memAluOut[7:0]] <= memStoreData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid    <= 1'b0;
            wbRegWrite <= 1'b0;
            wbHalt     <= 1'b0;
        end else begin
            wbValid    <= memValid;
            wbRegWrite <= memRegWrite;
            wbHalt     <= memHalt;
        end
    end

    always_ff @(posedge clk) begin
        wbAluOut   <= memAluOut;
        wbMemOut   <= readData;
        wbMemToReg <= memToReg;
        wbDest     <= memDest;
    end

endmodule
`default_nettype wire

//--- rtl/proc.sv
/* Top level of the five-stage core. Connects fetch, decode, execute and
   memory, selects the writeback value and keeps the halted and err flags */
`timescale 1ns/1ps
`default_nettype none

module proc import isaPkg::*, pipePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      imemWrEn,
    input  imemAddr_t imemAddr,
    input  instr_t    imemData,
    input  logic      start,
    output logic      wbValid,
    output regAddr_t  wbAddr,
    output word_t     wbData,
    output logic      halted,
    output logic      err
);

    // IF/ID and decode feedback
    instr_t   ifInstr;
    word_t    ifPcNext;
    logic     ifValid;
    logic     branchTaken;
    word_t    branchTarget;
    logic     haltSeen;
    logic     illegalOp;

    // ID/EX
    word_t    exRsVal;
    word_t    exRtVal;
    word_t    exImm;
    aluOp_t   exAluOp;
    logic     exAluSrcImm;
    logic     exMemEn;
    logic     exMemWr;
    logic     exMemToReg;
    logic     exRegWrite;
    logic     exHalt;
    regAddr_t exDest;
    logic     exValid;

    // EX/MEM
    word_t    memAluOut;
    word_t    memStoreData;
    logic     memEn;
    logic     memWr;
    logic     memToReg;
    logic     memRegWrite;
    logic     memHalt;
    regAddr_t memDest;
    logic     memValid;

    // MEM/WB
    word_t    retAluOut;
    word_t    retMemOut;
    logic     retMemToReg;
    logic     retRegWrite;
    logic     retHalt;
    regAddr_t retDest;
    logic     retValid;

    logic     haltedQ;
    logic     errQ;
    logic     haltRetire;

    fetch u_fetch (
        .clk(clk), .reset(reset),
        .imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
        .start(start),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .haltSeen(haltSeen),
        .ifInstr(ifInstr), .ifPcNext(ifPcNext), .ifValid(ifValid)
    );

    decode u_decode (
        .clk(clk), .reset(reset),
        .ifInstr(ifInstr), .ifPcNext(ifPcNext), .ifValid(ifValid),
        .wbEn(wbValid), .wbAddr(wbAddr), .wbData(wbData),          // Regfile write port
        .branchTaken(branchTaken), .branchTarget(branchTarget), .haltSeen(haltSeen),
        .exRsVal(exRsVal), .exRtVal(exRtVal), .exImm(exImm),
        .exAluOp(exAluOp), .exAluSrcImm(exAluSrcImm),
        .exMemEn(exMemEn), .exMemWr(exMemWr), .exMemToReg(exMemToReg),
        .exRegWrite(exRegWrite), .exHalt(exHalt), .exDest(exDest),
        .exValid(exValid), .illegalOp(illegalOp)
    );

    execute u_execute (
        .clk(clk), .reset(reset),
        .exRsVal(exRsVal), .exRtVal(exRtVal), .exImm(exImm),
        .exAluOp(exAluOp), .exAluSrcImm(exAluSrcImm),
        .exMemEn(exMemEn), .exMemWr(exMemWr), .exMemToReg(exMemToReg),
        .exRegWrite(exRegWrite), .exHalt(exHalt), .exDest(exDest), .exValid(exValid),
        .memAluOut(memAluOut), .memStoreData(memStoreData),
        .memEn(memEn), .memWr(memWr), .memToReg(memToReg),
        .memRegWrite(memRegWrite), .memHalt(memHalt), .memDest(memDest),
        .memValid(memValid)
    );

    memory u_memory (
        .clk(clk), .reset(reset),
        .memAluOut(memAluOut), .memStoreData(memStoreData),
        .memEn(memEn), .memWr(memWr), .memToReg(memToReg),
        .memRegWrite(memRegWrite), .memHalt(memHalt), .memDest(memDest),
        .memValid(memValid),
        .wbAluOut(retAluOut), .wbMemOut(retMemOut), .wbMemToReg(retMemToReg),
        .wbRegWrite(retRegWrite), .wbHalt(retHalt), .wbDest(retDest),
        .wbValid(retValid)
    );

    // Writeback mux and retire strobe
    assign wbData     = retMemToReg ? retMemOut : retAluOut;
    assign wbAddr     = retDest;
    assign wbValid    = retValid & retRegWrite;
    assign haltRetire = retValid & retHalt;

    always_ff @(posedge clk) begin
        if (reset) begin
            haltedQ <= 1'b0;
            errQ    <= 1'b0;
        end else begin
            haltedQ <= haltedQ | haltRetire;
            errQ    <= errQ | illegalOp;        // Sticky until reset
        end
    end

    assign halted = haltedQ | haltRetire;       // High in HALT's own writeback slot
    assign err    = errQ;

endmodule
`default_nettype wire

//--- verilog.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
fetch/fetch.sv
decode/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/proc.sv
bench/proc_chk.sv
bench/proc_tb.sv
